//--- axi_defines.svh
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// full AXI port widths, shared by the lite side
`define AXI_ADDR_W 20
`define AXI_DATA_W 16
`define AXI_ID_W 4
`define AXI_STRB_W (`AXI_DATA_W / 8)

// beat and outstanding counters, up to 256 beats per burst
`define AXI_CNT_W 9

`endif

//--- axi_pkg.sv
`include "axi_defines.svh"

package axi_pkg;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  // ordered so that a larger code is a worse response
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_ID_W-1:0]   id;
    logic [7:0]             len;   // beats minus one
    logic [2:0]             size;  // log2 of bytes per beat
    axi_burst_e             burst;
  } axi_aw_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
    logic                   last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    axi_resp_e            resp;
  } axi_b_t;

endpackage

//--- axil_pkg.sv
`include "axi_defines.svh"

package axil_pkg;

  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } axil_w_t;

  // lite B shares the response encoding of the full port
  typedef struct packed {
    axi_pkg::axi_resp_e resp;
  } axil_b_t;

endpackage

//--- burst_addr_gen.sv
`timescale 1ns/100ps
`include "axi_defines.svh"

module burst_addr_gen import axi_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   aw_take,
  input  axi_aw_t                aw,
  input  logic                   beat_take,
  output logic [`AXI_ADDR_W-1:0] beat_addr,
  output logic                   last_beat
);

  localparam int ADDR_W   = `AXI_ADDR_W;
  localparam int SIZE_MAX = $clog2(`AXI_STRB_W);

  logic [ADDR_W-1:0]        addr_q;
  logic [7:0]               len_q;
  logic [2:0]               size_q;
  axi_burst_e               burst_q;
  logic [`AXI_CNT_W-1:0]    beat_cnt_q;
  logic [ADDR_W-1:0]        step_bytes;
  logic [ADDR_W-1:0]        next_addr;

  assign step_bytes = ADDR_W'(1) << size_q;

  // incr aligns an unaligned start down before stepping
  assign next_addr = (burst_q == INCR) ?
                     ((addr_q & ~(step_bytes - 1'b1)) + step_bytes) : addr_q;

  assign beat_addr = addr_q;
  assign last_beat = (beat_cnt_q == {1'b0, len_q});

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_cnt_q <= '0;
      len_q      <= '0;
    end else if (aw_take) begin
      beat_cnt_q <= '0;
      len_q      <= aw.len;
    end else if (beat_take) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_take) begin
      addr_q  <= aw.addr;
      size_q  <= aw.size;
      burst_q <= aw.burst;
    end else if (beat_take) begin
      addr_q  <= next_addr;
    end
  end

  a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    aw_take |-> aw.burst != WRAP)
    else $error("wrap burst is not supported");

  a_size_fits: assert property (@(posedge clk) disable iff (!rst_n)
    aw_take |-> aw.size <= SIZE_MAX)
    else $error("burst size wider than data bus");

endmodule

//--- wr_ctrl_fsm.sv
`timescale 1ns/100ps
`include "axi_defines.svh"

module wr_ctrl_fsm import axi_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 s_aw_valid,
  output logic                 s_aw_ready,
  input  logic [`AXI_ID_W-1:0] aw_id,
  input  logic                 s_w_valid,
  input  logic                 s_w_last,
  output logic                 s_w_ready,
  input  logic                 slices_ready,
  input  logic                 last_beat,
  input  logic                 all_done,
  input  axi_resp_e            worst_resp,
  output axi_b_t               s_b,
  output logic                 s_b_valid,
  input  logic                 s_b_ready,
  output logic                 aw_take,
  output logic                 beat_take
);

  typedef enum logic [1:0] {
    IDLE,
    BURST,
    RESP
  } state_e;

  state_e               state_q;
  state_e               state_d;
  logic                 b_valid_q;
  logic [`AXI_ID_W-1:0] id_q;

  assign s_aw_ready = (state_q == IDLE);   // one burst in flight at most
  assign aw_take    = s_aw_valid && s_aw_ready;

  // leaving BURST on the last beat closes the W channel
  assign s_w_ready  = (state_q == BURST) && slices_ready;
  assign beat_take  = s_w_valid && s_w_ready;

  assign s_b_valid  = b_valid_q;
  assign s_b.id     = id_q;
  assign s_b.resp   = worst_resp;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (aw_take) state_d = BURST;
      end
      BURST: begin
        if (beat_take && last_beat) state_d = RESP;
      end
      RESP: begin
        if (b_valid_q && s_b_ready) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      b_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (b_valid_q && s_b_ready) begin
        b_valid_q <= 1'b0;
      end else if (state_q == RESP && all_done) begin
        b_valid_q <= 1'b1;   // every lite B is in
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_take) id_q <= aw_id;
  end

  // wlast must agree with the beat count derived from len
  a_last_match: assert property (@(posedge clk) disable iff (!rst_n)
    beat_take |-> s_w_last == last_beat)
    else $error("wlast does not match awlen");

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_b_valid && !s_b_ready |=> s_b_valid && $stable(s_b))
    else $error("B dropped or changed before handshake");

endmodule

//--- lite_req_slice.sv
`timescale 1ns/100ps

module lite_req_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  output logic     can_push,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t   mem [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       pop;

  assign out_valid = (count_q != 2'd0);
  assign out_data  = mem[rd_ptr_q];
  assign pop       = out_valid && out_ready;
  assign can_push  = (count_q != 2'd2) || pop;   // room once this pop is done

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr_q] <= push_data;
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> can_push)
    else $error("push into full slice");

endmodule

//--- resp_accum.sv
`timescale 1ns/100ps
`include "axi_defines.svh"

module resp_accum import axi_pkg::*, axil_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      clear,
  input  logic      beat_take,
  input  axil_b_t   m_b,
  input  logic      m_b_valid,
  output logic      m_b_ready,
  output logic      all_done,
  output axi_resp_e worst_resp
);

  logic [`AXI_CNT_W-1:0] cnt_q;
  axi_resp_e             worst_q;
  logic                  b_take;

  assign m_b_ready  = (cnt_q != '0);   // only accept what we issued
  assign b_take     = m_b_valid && m_b_ready;
  assign all_done   = (cnt_q == '0);
  assign worst_resp = worst_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + {{(`AXI_CNT_W-1){1'b0}}, beat_take}
                     - {{(`AXI_CNT_W-1){1'b0}}, b_take};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      worst_q <= OKAY;
    end else if (b_take && m_b.resp > worst_q) begin
      worst_q <= m_b.resp;   // higher code wins
    end
  end

  // a lite slave answering with nothing outstanding would underflow the count
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    m_b_valid && !beat_take |-> cnt_q != '0)
    else $error("lite B with no write outstanding");

endmodule

//--- axi_axil_wr_adapter.sv
`timescale 1ns/100ps
`include "axi_defines.svh"

module axi_axil_wr_adapter import axi_pkg::*, axil_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  axi_aw_t  s_aw,
  input  logic     s_aw_valid,
  output logic     s_aw_ready,
  input  axi_w_t   s_w,
  input  logic     s_w_valid,
  output logic     s_w_ready,
  output axi_b_t   s_b,
  output logic     s_b_valid,
  input  logic     s_b_ready,
  output axil_aw_t m_aw,
  output logic     m_aw_valid,
  input  logic     m_aw_ready,
  output axil_w_t  m_w,
  output logic     m_w_valid,
  input  logic     m_w_ready,
  input  axil_b_t  m_b,
  input  logic     m_b_valid,
  output logic     m_b_ready
);

  logic                   aw_take;
  logic                   beat_take;
  logic                   last_beat;
  logic                   all_done;
  axi_resp_e              worst_resp;
  logic [`AXI_ADDR_W-1:0] beat_addr;
  logic                   aw_can_push;
  logic                   w_can_push;
  logic                   slices_ready;
  axil_aw_t               aw_push;
  axil_w_t                w_push;

  assign slices_ready = aw_can_push && w_can_push;   // both lite channels need room
  assign aw_push.addr = beat_addr;
  assign w_push.data  = s_w.data;
  assign w_push.strb  = s_w.strb;

  wr_ctrl_fsm fsm_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_aw_valid  (s_aw_valid),
    .s_aw_ready  (s_aw_ready),
    .aw_id       (s_aw.id),
    .s_w_valid   (s_w_valid),
    .s_w_last    (s_w.last),
    .s_w_ready   (s_w_ready),
    .slices_ready(slices_ready),
    .last_beat   (last_beat),
    .all_done    (all_done),
    .worst_resp  (worst_resp),
    .s_b         (s_b),
    .s_b_valid   (s_b_valid),
    .s_b_ready   (s_b_ready),
    .aw_take     (aw_take),
    .beat_take   (beat_take)
  );

  burst_addr_gen addr_gen_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_take  (aw_take),
    .aw       (s_aw),
    .beat_take(beat_take),
    .beat_addr(beat_addr),
    .last_beat(last_beat)
  );

  resp_accum resp_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (aw_take),
    .beat_take (beat_take),
    .m_b       (m_b),
    .m_b_valid (m_b_valid),
    .m_b_ready (m_b_ready),
    .all_done  (all_done),
    .worst_resp(worst_resp)
  );

  lite_req_slice #(.payload_t(axil_aw_t)) aw_slice_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (beat_take),
    .push_data(aw_push),
    .can_push (aw_can_push),
    .out_data (m_aw),
    .out_valid(m_aw_valid),
    .out_ready(m_aw_ready)
  );

  lite_req_slice #(.payload_t(axil_w_t)) w_slice_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (beat_take),
    .push_data(w_push),
    .can_push (w_can_push),
    .out_data (m_w),
    .out_valid(m_w_valid),
    .out_ready(m_w_ready)
  );

endmodule

//--- tb_axi_axil_wr_adapter.sv
`timescale 1ns/100ps
`include "axi_defines.svh"

module tb_axi_axil_wr_adapter import axi_pkg::*, axil_pkg::*; ();

  localparam int N_BURSTS       = 200;
  localparam int TIMEOUT_CYCLES = N_BURSTS * 8 * 40;   // bursts x max beats x slack

  logic     clk;
  logic     rst_n;
  axi_aw_t  s_aw;
  logic     s_aw_valid;
  logic     s_aw_ready;
  axi_w_t   s_w;
  logic     s_w_valid;
  logic     s_w_ready;
  axi_b_t   s_b;
  logic     s_b_valid;
  logic     s_b_ready;
  axil_aw_t m_aw;
  logic     m_aw_valid;
  logic     m_aw_ready;
  axil_w_t  m_w;
  logic     m_w_valid;
  logic     m_w_ready;
  axil_b_t  m_b;
  logic     m_b_valid;
  logic     m_b_ready;

  logic [`AXI_ADDR_W-1:0] exp_addr [$];   // lite addresses still to come
  axil_w_t                exp_w [$];
  logic [`AXI_ID_W-1:0]   exp_id;
  int                     exp_len;
  logic                   burst_open;
  int                     w_beat_cnt;
  int                     lite_aw_cnt;
  int                     lite_w_cnt;
  int                     lite_b_cnt;
  int                     aw_total;
  int                     w_total;
  int                     cycles;
  axi_resp_e              worst_seen;

  axi_axil_wr_adapter dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_aw      (s_aw),
    .s_aw_valid(s_aw_valid),
    .s_aw_ready(s_aw_ready),
    .s_w       (s_w),
    .s_w_valid (s_w_valid),
    .s_w_ready (s_w_ready),
    .s_b       (s_b),
    .s_b_valid (s_b_valid),
    .s_b_ready (s_b_ready),
    .m_aw      (m_aw),
    .m_aw_valid(m_aw_valid),
    .m_aw_ready(m_aw_ready),
    .m_w       (m_w),
    .m_w_valid (m_w_valid),
    .m_w_ready (m_w_ready),
    .m_b       (m_b),
    .m_b_valid (m_b_valid),
    .m_b_ready (m_b_ready)
  );

  always #10 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "check %s mismatched", name);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  // incr steps from the size-aligned address, fixed stays put
  function automatic logic [`AXI_ADDR_W-1:0] model_next_addr(
    input logic [`AXI_ADDR_W-1:0] cur, input logic [2:0] size, input axi_burst_e burst);
    logic [`AXI_ADDR_W-1:0] bytes;
    bytes = `AXI_ADDR_W'(1) << size;
    if (burst == FIXED) return cur;
    return (cur & ~(bytes - 1)) + bytes;
  endfunction

  task automatic run_burst();
    axi_aw_t                aw;
    axi_w_t                 beat;
    axil_w_t                lw;
    logic [`AXI_ADDR_W-1:0] addr;
    repeat ($urandom_range(0, 2)) @(negedge clk);
    aw.addr  = $urandom;
    aw.id    = $urandom;
    aw.len   = $urandom_range(0, 7);
    aw.size  = $urandom_range(0, 1);
    aw.burst = ($urandom_range(0, 1) != 0) ? INCR : FIXED;
    exp_id   = aw.id;
    exp_len  = aw.len;
    s_aw       = aw;
    s_aw_valid = 1'b1;
    do @(posedge clk); while (!s_aw_ready);
    @(negedge clk);
    s_aw_valid = 1'b0;
    addr = aw.addr;
    for (int i = 0; i <= aw.len; i++) begin
      while ($urandom_range(0, 3) == 0) @(negedge clk);   // gap on W valid
      beat.data = $urandom;
      beat.strb = $urandom;
      beat.last = (i == aw.len);
      lw.data = beat.data;
      lw.strb = beat.strb;
      exp_w.push_back(lw);
      exp_addr.push_back(addr);
      addr = model_next_addr(addr, aw.size, aw.burst);
      s_w       = beat;
      s_w_valid = 1'b1;
      do @(posedge clk); while (!s_w_ready);
      @(negedge clk);
      s_w_valid = 1'b0;
    end
    do begin
      @(negedge clk);
      s_b_ready = ($urandom_range(0, 2) != 0);
      @(posedge clk);
    end while (!(s_b_valid && s_b_ready));
    @(negedge clk);
    s_b_ready = 1'b0;
  endtask

  // lite slave ready stalls
  always @(negedge clk) begin
    m_aw_ready = ($urandom_range(0, 3) != 0);
    m_w_ready  = ($urandom_range(0, 3) != 0);
  end

  // lite B goes out once both AW and W of a write are in
  initial begin : lite_b_driver
    int issued;
    issued = 0;
    forever begin
      @(negedge clk);
      m_b_valid = 1'b0;
      if (rst_n && ((aw_total < w_total) ? aw_total : w_total) > issued) begin
        repeat ($urandom_range(0, 3)) @(negedge clk);
        m_b.resp  = axi_resp_e'($urandom_range(0, 3));
        m_b_valid = 1'b1;
        do @(posedge clk); while (!m_b_ready);
        issued++;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (burst_open) check_eq("aw_ready_during_burst", 0, s_aw_ready);
      if (!burst_open || w_beat_cnt > exp_len) check_eq("w_ready_closed", 0, s_w_ready);
      check_eq("m_b_ready", w_beat_cnt != lite_b_cnt, m_b_ready);   // lite writes outstanding
      if (s_aw_valid && s_aw_ready) begin
        burst_open  = 1'b1;
        w_beat_cnt  = 0;
        lite_aw_cnt = 0;
        lite_w_cnt  = 0;
        lite_b_cnt  = 0;
        worst_seen  = OKAY;
      end
      if (s_w_valid && s_w_ready) w_beat_cnt++;
      if (m_aw_valid && m_aw_ready) begin
        if (exp_addr.size() == 0) abort_run("lite AW issued with no AXI beat behind it");
        else check_eq("lite_aw_addr", exp_addr.pop_front(), m_aw.addr);
        lite_aw_cnt++;
        aw_total++;
      end
      if (m_w_valid && m_w_ready) begin
        if (exp_w.size() == 0) abort_run("lite W issued with no AXI beat behind it");
        else check_eq("lite_w_data_strb", exp_w.pop_front(), m_w);
        lite_w_cnt++;
        w_total++;
      end
      if (m_b_valid && m_b_ready) begin
        lite_b_cnt++;
        if (m_b.resp > worst_seen) worst_seen = m_b.resp;
      end
      if (s_b_valid) begin
        check_eq("b_only_in_burst", 1, burst_open);
        check_eq("b_after_lite_b", exp_len + 1, lite_b_cnt);
      end
      if (s_b_valid && s_b_ready) begin
        check_eq("b_id", exp_id, s_b.id);
        check_eq("b_resp", worst_seen, s_b.resp);
        check_eq("lite_aw_count", exp_len + 1, lite_aw_cnt);
        check_eq("lite_w_count", exp_len + 1, lite_w_cnt);
        burst_open = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) abort_run("timeout: bursts did not complete");
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    s_aw        = '0;
    s_aw_valid  = 1'b0;
    s_w         = '0;
    s_w_valid   = 1'b0;
    s_b_ready   = 1'b0;
    m_aw_ready  = 1'b0;
    m_w_ready   = 1'b0;
    m_b         = '0;
    m_b_valid   = 1'b0;
    burst_open  = 1'b0;
    w_beat_cnt  = 0;
    lite_aw_cnt = 0;
    lite_w_cnt  = 0;
    lite_b_cnt  = 0;
    aw_total    = 0;
    w_total     = 0;
    cycles      = 0;
    worst_seen  = OKAY;
    exp_id      = '0;
    exp_len     = 0;
    void'($urandom(32'h8fbf834b));
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_eq("reset_m_aw_valid", 0, m_aw_valid);
    check_eq("reset_m_w_valid", 0, m_w_valid);
    check_eq("reset_s_b_valid", 0, s_b_valid);
    check_eq("reset_s_aw_ready", 1, s_aw_ready);
    for (int n = 0; n < N_BURSTS; n++) begin
      run_burst();
    end
    repeat (4) @(negedge clk);
    // adapter drained and back in idle
    check_eq("end_s_aw_ready", 1, s_aw_ready);
    check_eq("end_m_aw_valid", 0, m_aw_valid);
    check_eq("end_m_w_valid", 0, m_w_valid);
    check_eq("end_s_b_valid", 0, s_b_valid);
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- build.f
+incdir+.
axi_pkg.sv
axil_pkg.sv
burst_addr_gen.sv
wr_ctrl_fsm.sv
lite_req_slice.sv
resp_accum.sv
axi_axil_wr_adapter.sv
tb_axi_axil_wr_adapter.sv
